/* Makefile */
# Verilator build and run for the video frame DMA

VERILATOR ?= verilator
TOP       ?= videoDmaTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+logic
logic/videoDmaPkg.sv
logic/pixelFifo.sv
logic/frameWriteDma.sv
logic/frameReadDma.sv
logic/memArbiter.sv
logic/frameRam.sv
logic/dmaApbRegs.sv
logic/videoDmaTop.sv
sim/videoDmaTb.sv

/* logic/dmaApbRegs.sv */
/*
  APB register block
  Control, frame length, status and frame count registers,
  zero wait states, errors for bad addresses and bad writes
*/
`timescale 1ns/1ps
`include "videoDma_defs.svh"

module dmaApbRegs
	import videoDmaPkg::*;
(
	input  logic     iClk,
	input  logic     rstN,
	// APB
	input  apbAdrsT  paddr,
	input  logic     psel,
	input  logic     penable,
	input  logic     pwrite,
	input  apbDataT  pwdata,
	output apbDataT  prdata,
	output logic     pready,
	output logic     pslverr,
	// Register outputs
	output logic     enable,
	output frameLenT frameLen,
	// Status inputs
	input  logic     frontValid,
	input  logic     backReady,
	input  logic     frontSel,
	input  logic     fifoFull,
	input  frameCntT frameCnt
);

	logic access;
	logic hitCtrl;
	logic hitLen;
	logic hitStat;
	logic hitCnt;
	logic lenBad;

	// ----------------------------------------
	// Decode
	// ----------------------------------------
	assign access  = psel && penable;
	assign hitCtrl = (paddr == `VDMA_REG_CTRL);
	assign hitLen  = (paddr == `VDMA_REG_LEN);
	assign hitStat = (paddr == `VDMA_REG_STAT);
	assign hitCnt  = (paddr == `VDMA_REG_CNT);
	assign lenBad  = (pwdata == '0) || (pwdata > `VDMA_BUF_WORDS);
	assign pready  = 1'b1;

	// Unmapped, read-only write, or length out of range
	assign pslverr = access && (
		!(hitCtrl || hitLen || hitStat || hitCnt) ||
		(pwrite && (hitStat || hitCnt)) ||
		(pwrite && hitLen && !enable && lenBad));

	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			enable   <= 1'b0;
			frameLen <= frameLenT'(`VDMA_BUF_WORDS);   // Full buffer
		end
		else if (access && pwrite)
		begin
			if (hitCtrl)
				enable <= pwdata[0];
			// Length frozen while running
			if (hitLen && !enable && !lenBad)
				frameLen <= pwdata[`VDMA_LEN_W-1:0];
		end
	end

	// Read mux, data valid in the access cycle
	always_comb
	begin
		prdata = '0;
		if (hitCtrl)
			prdata = {31'b0, enable};
		else if (hitLen)
			prdata = apbDataT'(frameLen);
		else if (hitStat)
			prdata = {28'b0, fifoFull, frontSel, backReady, frontValid};
		else if (hitCnt)
			prdata = apbDataT'(frameCnt);
	end

endmodule

/* logic/frameRam.sv */
/*
  Frame RAM
  Single-port memory for the two frame buffers, registered read
*/
`timescale 1ns/1ps
`include "videoDma_defs.svh"

module frameRam
	import videoDmaPkg::*;
(
	input  logic    iClk,
	input  memAdrsT memAdrs,
	input  logic    memWe,
	input  pixelT   memWd,
	output pixelT   memRd
);

	// Lower half buffer 0, upper half buffer 1
	pixelT mem [2*`VDMA_BUF_WORDS];

	always_ff @(posedge iClk)
	begin
		if (memWe)
			mem[memAdrs] <= memWd;
		memRd <= mem[memAdrs];     // Old data on a write cycle
	end

endmodule

/* logic/frameReadDma.sv */
/*
  Frame read DMA
  Streams the front buffer out with a start-of-frame flag, repeating it
  until a new frame is ready, and swaps the buffers at frame end
*/
`timescale 1ns/1ps
`include "videoDma_defs.svh"

module frameReadDma
	import videoDmaPkg::*;
(
	input  logic     iClk,
	input  logic     rstN,
	input  logic     enable,
	input  frameLenT frameLen,
	input  logic     backReady,
	output logic     swapAck,
	output logic     frontSel,
	output logic     frontValid,
	output frameCntT frameCnt,
	output logic     rdReq,
	output memAdrsT  rdAdrs,
	input  logic     rdGnt,
	input  logic     rdValid,
	input  pixelT    rdData,
	output pixelT    pixData,
	output logic     pixValid,
	output logic     pixSof,
	input  logic     pixReady
);

	rdStateT  state;
	frameLenT reqIdx;       // Next pixel to request
	logic [1:0] occ;        // In flight plus held
	logic [1:0] bufCnt;     // Skid entries used
	pixelT    buf0;
	pixelT    buf1;
	logic     sof0;
	logic     sof1;
	logic     sofPend;      // Sof of the word on rdData
	logic     pop;
	logic     shift;
	logic     store;
	logic     doSwap;

	assign rdReq  = enable && (state == RD_STREAM) && (occ < 2'd2);
	assign rdAdrs = {frontSel, reqIdx[`VDMA_MEM_AW-2:0]};

	// ----------------------------------------
	// Output side of the skid
	// ----------------------------------------
	assign pixValid = enable && ((bufCnt != 2'd0) || rdValid);
	assign pixData  = (bufCnt != 2'd0) ? buf0 : rdData;    // Bypass when empty
	assign pixSof   = (bufCnt != 2'd0) ? sof0 : sofPend;
	assign pop      = pixValid && pixReady;
	assign shift    = pop && (bufCnt != 2'd0);
	assign store    = rdValid && !(pop && (bufCnt == 2'd0));

	// Swap only at a frame boundary with nothing left in the pipe
	assign doSwap = enable && backReady &&
		((state == RD_IDLE) || ((state == RD_DRAIN) && (occ == 2'd0)));

	// Reader FSM, counters and swap
	always_ff @(posedge iClk)
	begin
		if (!rstN || !enable)
		begin
			state      <= RD_IDLE;
			reqIdx     <= '0;
			occ        <= '0;
			bufCnt     <= '0;
			frontSel   <= 1'b0;
			frontValid <= 1'b0;
			frameCnt   <= '0;
			swapAck    <= 1'b0;
		end
		else
		begin
			occ     <= occ + {1'b0, rdGnt} - {1'b0, pop};
			bufCnt  <= bufCnt + {1'b0, store} - {1'b0, shift};
			swapAck <= doSwap;                  // One cycle pulse
			if (doSwap)
			begin
				frontSel   <= ~frontSel;
				frontValid <= 1'b1;
				frameCnt   <= frameCnt + 1'b1;
			end
			case (state)
				RD_IDLE:
					if (backReady)
						state <= RD_STREAM;
				RD_STREAM:
					if (rdGnt)
					begin
						if (reqIdx == frameLen - 1'b1)
						begin
							reqIdx <= '0;
							state  <= RD_DRAIN;
						end
						else
							reqIdx <= reqIdx + 1'b1;
					end
				RD_DRAIN:
					if (occ == 2'd0)
						state <= RD_STREAM;        // Next frame, new or repeated
				default:
					state <= RD_IDLE;
			endcase
		end
	end

	// Skid payload
	always_ff @(posedge iClk)
	begin
		sofPend <= rdGnt && (reqIdx == '0);
		if (shift)
		begin
			buf0 <= buf1;
			sof0 <= sof1;
		end
		if (store)
		begin
			if ((bufCnt == 2'd0) || ((bufCnt == 2'd1) && shift))
			begin
				buf0 <= rdData;
				sof0 <= sofPend;
			end
			else
			begin
				buf1 <= rdData;
				sof1 <= sofPend;
			end
		end
	end

endmodule

/* logic/frameWriteDma.sv */
/*
  Frame write DMA
  Moves pixels from the input FIFO into the back buffer, one per grant,
  then raises backReady and holds until the reader swaps
*/
`timescale 1ns/1ps
`include "videoDma_defs.svh"

module frameWriteDma
	import videoDmaPkg::*;
(
	input  logic     iClk,
	input  logic     rstN,
	input  logic     enable,
	input  frameLenT frameLen,
	input  pixelT    fifoData,
	input  logic     fifoEmpty,
	output logic     fifoPop,
	output logic     wrReq,
	output memAdrsT  wrAdrs,
	output pixelT    wrData,
	input  logic     wrGnt,
	input  logic     frontSel,
	input  logic     swapAck,
	output logic     backReady
);

	wrStateT  state;
	frameLenT idx;          // Index of the pixel in the request slot
	pixelT    slotData;
	logic     lastPix;

	assign lastPix = (idx == frameLen - 1'b1);
	assign wrReq   = (state == WR_MOVE);
	assign wrData  = slotData;
	// Back buffer is the one not on display
	assign wrAdrs  = {~frontSel, idx[`VDMA_MEM_AW-2:0]};

	// Refill when the slot is empty or its pixel is granted now,
	// never beyond the frame end
	assign fifoPop = enable && !fifoEmpty &&
		((state == WR_IDLE) || (wrReq && wrGnt && !lastPix));

	// ----------------------------------------
	// Writer FSM
	// ----------------------------------------
	always_ff @(posedge iClk)
	begin
		if (!rstN || !enable)
		begin
			state     <= WR_IDLE;
			idx       <= '0;
			backReady <= 1'b0;
		end
		else
		begin
			case (state)
				WR_IDLE:
					if (fifoPop)
						state <= WR_MOVE;
				WR_MOVE:
					if (wrGnt)
					begin
						if (lastPix)
						begin
							state     <= WR_HOLD;      // Whole frame in RAM
							idx       <= '0;
							backReady <= 1'b1;
						end
						else
						begin
							idx <= idx + 1'b1;
							if (!fifoPop)
								state <= WR_IDLE;      // FIFO ran dry
						end
					end
				WR_HOLD:
					if (swapAck)
					begin
						state     <= WR_IDLE;
						backReady <= 1'b0;
					end
				default:
					state <= WR_IDLE;
			endcase
		end
	end

	// Pixel held for the request
	always_ff @(posedge iClk)
	begin
		if (fifoPop)
			slotData <= fifoData;
	end

endmodule

/* logic/memArbiter.sv */
/*
  RAM port arbiter
  Round-robin between the write and read DMA on the single RAM port,
  returns read data one cycle after the grant
*/
`timescale 1ns/1ps
`include "videoDma_defs.svh"

module memArbiter
	import videoDmaPkg::*;
(
	input  logic    iClk,
	input  logic    rstN,
	// Writer port
	input  logic    wrReq,
	input  memAdrsT wrAdrs,
	input  pixelT   wrData,
	output logic    wrGnt,
	// Reader port
	input  logic    rdReq,
	input  memAdrsT rdAdrs,
	output logic    rdGnt,
	output logic    rdValid,
	output pixelT   rdData,
	// RAM side
	output memAdrsT memAdrs,
	output logic    memWe,
	output pixelT   memWd,
	input  pixelT   memRd
);

	logic lastWr;   // Writer won the last granted cycle

	// ----------------------------------------
	// Grant
	// ----------------------------------------
	// Sole requester wins at once, a tie goes to whoever lost last
	assign wrGnt = wrReq && (!rdReq || !lastWr);
	assign rdGnt = rdReq && !wrGnt;

	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			lastWr  <= 1'b0;
			rdValid <= 1'b0;
		end
		else
		begin
			if (wrGnt || rdGnt)
				lastWr <= wrGnt;
			rdValid <= rdGnt;             // Matches the RAM read latency
		end
	end

	// Steering
	assign memAdrs = wrGnt ? wrAdrs : rdAdrs;
	assign memWe   = wrGnt;
	assign memWd   = wrData;
	assign rdData  = memRd;

endmodule

/* logic/pixelFifo.sv */
/*
  Input pixel FIFO
  Circular buffer between the pixel source and the write DMA,
  head is visible combinationally, flush empties it in one cycle
*/
`timescale 1ns/1ps
`include "videoDma_defs.svh"

module pixelFifo
	import videoDmaPkg::*;
(
	input  logic  iClk,
	input  logic  rstN,
	input  logic  flush,
	input  pixelT pushData,
	input  logic  push,
	output logic  full,
	output pixelT popData,
	input  logic  pop,
	output logic  empty
);

	localparam int PtrW = $clog2(`VDMA_FIFO_DEPTH);

	pixelT           mem [`VDMA_FIFO_DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0]   count;     // One bit wider to tell full from empty
	logic            doPush;
	logic            doPop;

	assign full    = (count == (PtrW+1)'(`VDMA_FIFO_DEPTH));
	assign empty   = (count == '0);
	assign doPush  = push && !full;
	assign doPop   = pop && !empty;
	assign popData = mem[rdPtr];          // Head straight out

	// Storage
	always_ff @(posedge iClk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	// Pointers and fill level
	always_ff @(posedge iClk)
	begin
		if (!rstN || flush)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;    // Wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= count + {{PtrW{1'b0}}, doPush} - {{PtrW{1'b0}}, doPop};
		end
	end

endmodule

/* logic/videoDmaPkg.sv */
/*
  Video frame DMA types
  Width typedefs shared by all blocks and the two DMA state encodings
*/
`include "videoDma_defs.svh"

package videoDmaPkg;

	typedef logic [`VDMA_PIX_W-1:0]  pixelT;
	typedef logic [`VDMA_MEM_AW-1:0] memAdrsT;    // {buffer, index}
	typedef logic [`VDMA_LEN_W-1:0]  frameLenT;   // Length or pixel index
	typedef logic [`VDMA_APB_AW-1:0] apbAdrsT;
	typedef logic [31:0]             apbDataT;
	typedef logic [`VDMA_CNT_W-1:0]  frameCntT;

	// Writer FSM
	typedef enum logic [1:0] {
		WR_IDLE,    // Request slot empty
		WR_MOVE,    // Pixel waiting for a grant
		WR_HOLD     // Frame done, waiting for swap
	} wrStateT;

	// Reader FSM
	typedef enum logic [1:0] {
		RD_IDLE,    // No frame shown yet
		RD_STREAM,  // Issuing reads
		RD_DRAIN    // Last read issued, emptying the skid
	} rdStateT;

endpackage

/* logic/videoDmaTop.sv */
/*
  Video frame DMA top
  Input FIFO, write and read DMA, RAM arbiter, frame RAM and APB registers
*/
`timescale 1ns/1ps
`include "videoDma_defs.svh"

module videoDmaTop
	import videoDmaPkg::*;
(
	input  logic    iClk,
	input  logic    rstN,
	// Pixel input
	input  pixelT   iPixData,
	input  logic    iPixValid,
	output logic    oPixReady,
	// Pixel output
	output pixelT   oPixData,
	output logic    oPixValid,
	output logic    oPixSof,
	input  logic    iPixReady,
	// APB
	input  apbAdrsT paddr,
	input  logic    psel,
	input  logic    penable,
	input  logic    pwrite,
	input  apbDataT pwdata,
	output apbDataT prdata,
	output logic    pready,
	output logic    pslverr
);

	logic     enable;
	frameLenT frameLen;
	logic     fifoFull;
	logic     fifoEmpty;
	logic     fifoPop;
	pixelT    fifoData;
	logic     backReady;
	logic     swapAck;
	logic     frontSel;
	logic     frontValid;
	frameCntT frameCnt;
	logic     wrReq;
	logic     wrGnt;
	memAdrsT  wrAdrs;
	pixelT    wrData;
	logic     rdReq;
	logic     rdGnt;
	logic     rdValid;
	memAdrsT  rdAdrs;
	pixelT    rdData;
	memAdrsT  memAdrs;
	logic     memWe;
	pixelT    memWd;
	pixelT    memRd;

	assign oPixReady = ~fifoFull;

	// ----------------------------------------
	// Control and input side
	// ----------------------------------------
	dmaApbRegs u_dmaApbRegs (
		.iClk(iClk), .rstN(rstN),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.enable(enable), .frameLen(frameLen),
		.frontValid(frontValid), .backReady(backReady), .frontSel(frontSel),
		.fifoFull(fifoFull), .frameCnt(frameCnt)
	);

	pixelFifo u_pixelFifo (
		.iClk(iClk), .rstN(rstN), .flush(~enable),     // Disable drops queued pixels
		.pushData(iPixData), .push(iPixValid), .full(fifoFull),
		.popData(fifoData), .pop(fifoPop), .empty(fifoEmpty)
	);

	frameWriteDma u_frameWriteDma (
		.iClk(iClk), .rstN(rstN), .enable(enable), .frameLen(frameLen),
		.fifoData(fifoData), .fifoEmpty(fifoEmpty), .fifoPop(fifoPop),
		.wrReq(wrReq), .wrAdrs(wrAdrs), .wrData(wrData), .wrGnt(wrGnt),
		.frontSel(frontSel), .swapAck(swapAck), .backReady(backReady)
	);

	// ----------------------------------------
	// Output side and memory
	// ----------------------------------------
	frameReadDma u_frameReadDma (
		.iClk(iClk), .rstN(rstN), .enable(enable), .frameLen(frameLen),
		.backReady(backReady), .swapAck(swapAck), .frontSel(frontSel),
		.frontValid(frontValid), .frameCnt(frameCnt),
		.rdReq(rdReq), .rdAdrs(rdAdrs), .rdGnt(rdGnt),
		.rdValid(rdValid), .rdData(rdData),
		.pixData(oPixData), .pixValid(oPixValid), .pixSof(oPixSof),
		.pixReady(iPixReady)
	);

	memArbiter u_memArbiter (
		.iClk(iClk), .rstN(rstN),
		.wrReq(wrReq), .wrAdrs(wrAdrs), .wrData(wrData), .wrGnt(wrGnt),
		.rdReq(rdReq), .rdAdrs(rdAdrs), .rdGnt(rdGnt),
		.rdValid(rdValid), .rdData(rdData),
		.memAdrs(memAdrs), .memWe(memWe), .memWd(memWd), .memRd(memRd)
	);

	frameRam u_frameRam (
		.iClk(iClk), .memAdrs(memAdrs), .memWe(memWe),
		.memWd(memWd), .memRd(memRd)
	);

endmodule

/* logic/videoDma_defs.svh */
/*
  Video frame DMA defines
  Pixel and memory widths, buffer size, FIFO depth and APB register map
*/
`ifndef VIDEODMA_DEFS_SVH
`define VIDEODMA_DEFS_SVH

// ----------------------------------------
// Data path and memory
// ----------------------------------------
`define VDMA_PIX_W      16     // Bits per pixel
`define VDMA_BUF_WORDS  256    // Words in one frame buffer
`define VDMA_MEM_AW     9      // Top bit picks the buffer
`define VDMA_LEN_W      9      // Holds 1..256
`define VDMA_FIFO_DEPTH 16
`define VDMA_CNT_W      16

// ----------------------------------------
// APB register map
// ----------------------------------------
`define VDMA_APB_AW     4
`define VDMA_REG_CTRL   4'h0
`define VDMA_REG_LEN    4'h4
`define VDMA_REG_STAT   4'h8
`define VDMA_REG_CNT    4'hC

`endif

/* sim/videoDmaStim.txt */
# op argA argB in hex. W adr data, X adr data (error), R adr expect,
# F count base, D frames base, Q cycles status, M random 0
R 0 0
R 4 100
R 8 0
R C 0
W 0 1
R 0 1
W 0 0
W 4 20
R 4 20
X 4 0
R 4 20
X 4 101
R 4 20
X 8 5
X C 1
X 2 0
W 0 1
F 20 1000
D 3 1000
R C 1
R 8 5
M 1 0
F 20 2000
F 20 3000
F 20 4000
F 20 5000
D 2 5000
M 0 0
R C 5
R 8 5
F 20 6000
F 20 7000
Q 100 F
D 2 7000
R C 7
W 0 0
R C 0
R 8 0
W 4 10
R 4 10
W 0 1
Q 20 0
F 10 8000
D 3 8000
R C 1

/* sim/videoDmaTb.sv */
/*
  Video frame DMA testbench
  Runs the command script against the DMA, models pushed frames
  and checks every output frame for content, length and order
*/
`timescale 1ns/1ps

module videoDmaTb;

	logic        iClk = 1'b0;
	logic        rstN = 1'b0;
	logic [15:0] iPixData = '0;
	logic        iPixValid = 1'b0;
	logic        oPixReady;
	logic [15:0] oPixData;
	logic        oPixValid;
	logic        oPixSof;
	logic        iPixReady = 1'b0;
	logic [3:0]  paddr = '0;
	logic        psel = 1'b0;
	logic        penable = 1'b0;
	logic        pwrite = 1'b0;
	logic [31:0] pwdata = '0;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	byte         ops[$];           // Script, one entry per command
	int unsigned argA[$];
	int unsigned argB[$];
	int unsigned pushQ[$];         // Pixels waiting for the input port
	int unsigned bases[$];         // Model of frames pushed since enable
	int unsigned lens[$];
	string       testName = "reset";
	int unsigned expLen = 256;
	int unsigned pixCount = 0;
	int unsigned waitBase = 0;
	int unsigned matchCount = 0;
	int          curIdx = 0;
	int          lastIdx = 0;
	int          k;
	bit          inFrame = 0;
	bit          holdLow = 0;
	bit          randMode = 0;

	videoDmaTop u_videoDmaTop (
		.iClk(iClk), .rstN(rstN),
		.iPixData(iPixData), .iPixValid(iPixValid), .oPixReady(oPixReady),
		.oPixData(oPixData), .oPixValid(oPixValid), .oPixSof(oPixSof),
		.iPixReady(iPixReady),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #4 iClk = ~iClk;       // 8 ns period

	task automatic checkValue(input string name, input int unsigned expVal,
		input int unsigned actVal);
		if (expVal !== actVal)
		begin
			$display("ERROR %s expected %0h actual %0h", name, expVal, actVal);
			$display("TEST RESULT: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	// Two-phase APB transfer, results sampled mid access phase
	task automatic apbXfer(input logic wr, input int unsigned adrs,
		input int unsigned data, output logic err, output int unsigned rdat);
		@(negedge iClk);
		psel   <= 1'b1;
		pwrite <= wr;
		paddr  <= adrs[3:0];
		pwdata <= data;
		@(negedge iClk);
		penable <= 1'b1;
		#2;
		err  = pslverr;
		rdat = prdata;
		checkValue({testName, " pready"}, 1, pready);    // No wait states
		@(negedge iClk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// ----------------------------------------
	// Input and ready drivers
	// ----------------------------------------
	always @(negedge iClk)
	begin
		iPixValid <= (pushQ.size() != 0);
		if (pushQ.size() != 0)
			iPixData <= pushQ[0][15:0];
		iPixReady <= holdLow ? 1'b0 : (randMode ? 1'($urandom % 2) : 1'b1);
	end

	always @(posedge iClk)
	begin
		if (iPixValid && oPixReady && pushQ.size() != 0)
			pushQ.pop_front();        // Accepted by the FIFO
	end

	// Output checker, frames split on sof
	always @(posedge iClk)
	begin
		if (rstN && oPixValid && iPixReady)
		begin
			if (oPixSof)
			begin
				checkValue({testName, " frame end"}, 0, inFrame);
				k = -1;
				foreach (bases[i])
					if (bases[i] == 32'(oPixData))
						k = i;
				checkValue({testName, " known frame"}, 1, k >= 0);
				// Repeat of the last frame or the next one, nothing skipped
				checkValue({testName, " frame order"}, 1,
					(k == lastIdx) || (k == lastIdx + 1));
				checkValue({testName, " frame length"}, lens[k], expLen);
				curIdx   = k;
				pixCount = 0;
				inFrame  = 1;
			end
			checkValue({testName, " sof position"}, 1, inFrame);
			checkValue({testName, " pixel"}, (bases[curIdx] + pixCount) & 16'hFFFF,
				oPixData);
			pixCount++;
			if (pixCount == expLen)
			begin
				inFrame = 0;
				lastIdx = curIdx;
				if (bases[curIdx] == waitBase)
					matchCount++;
			end
		end
	end

	// ----------------------------------------
	// Script runner
	// ----------------------------------------
	initial
	begin
		int          fd;
		int          n;
		int unsigned a;
		int unsigned b;
		int unsigned rdat;
		int unsigned lenRun;
		int unsigned limit;
		logic        err;
		byte         op;
		string       line;

		void'($urandom(32'h69889078));
		fd = $fopen("sim/videoDmaStim.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file sim/videoDmaStim.txt");
			$display("TEST RESULT: FAIL");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line[0] != "#")
			begin
				n = $sscanf(line, "%c %h %h", op, a, b);
				if (n == 3)
				begin
					ops.push_back(op);
					argA.push_back(a);
					argB.push_back(b);
				end
			end
		end
		$fclose(fd);

		// Time budget from pushed pixels, checked frames and holds
		lenRun = 256;
		limit  = 1000;
		foreach (ops[i])
		begin
			if (ops[i] == "W" && argA[i] == 4)
				lenRun = argB[i];
			if (ops[i] == "F")
				limit += 8 * argA[i];
			if (ops[i] == "D")
				limit += 8 * argA[i] * lenRun;
			if (ops[i] == "Q")
				limit += argA[i];
		end
		fork
			begin
				repeat (limit) @(posedge iClk);
				$display("Timeout after %0d cycles, the DMA stopped making progress", limit);
				$display("TEST RESULT: FAIL");
				$fatal(1, "timeout");
			end
		join_none

		repeat (5) @(negedge iClk);
		rstN = 1'b1;

		foreach (ops[i])
		begin
			a = argA[i];
			b = argB[i];
			testName = $sformatf("step %0d (%c)", i + 1, ops[i]);
			case (ops[i])
				"W", "X":
				begin
					apbXfer(1'b1, a, b, err, rdat);
					checkValue({testName, " pslverr"}, ops[i] == "X", err);
					if (a == 4 && ops[i] == "W")
						expLen = b;
					if (a == 0 && b[0] == 1'b0)
					begin
						// Disabled, everything queued is dropped
						pushQ.delete();
						bases.delete();
						lens.delete();
						inFrame = 0;
						lastIdx = 0;
					end
				end
				"R":
				begin
					apbXfer(1'b0, a, 0, err, rdat);
					checkValue({testName, " pslverr"}, 0, err);
					checkValue({testName, " read"}, b, rdat);
				end
				"F":
				begin
					bases.push_back(b);
					lens.push_back(a);
					for (int p = 0; p < a; p++)
						pushQ.push_back(b + p);
				end
				"D":
				begin
					matchCount = 0;
					waitBase   = b;
					while (matchCount < a)
						@(negedge iClk);
				end
				"Q":
				begin
					holdLow = 1;
					repeat (a) @(negedge iClk);
					apbXfer(1'b0, 8, 0, err, rdat);
					checkValue({testName, " status"}, b, rdat);
					checkValue({testName, " input ready"}, !b[3], oPixReady);
					holdLow = 0;
				end
				"M":
					randMode = a[0];
				default:
				begin
					$display("Unknown command %c in the stimulus file", ops[i]);
					$display("TEST RESULT: FAIL");
					$fatal(1, "bad script");
				end
			endcase
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
